// ==== common/dcache_pkg.sv ====
// shared cache geometry, operation codes and miss-unit states, referenced by scoped name
package dcache_pkg;

  // byte address and line geometry
  localparam int ADDR_W = 32;
  localparam int OFFSET_W = 6;

  // one L2 beat is one data-array word
  localparam int BEAT_W = 64;
  localparam int BEATS = 8;

  localparam int WAYS = 4;

  // load/store queue id
  localparam int ID_W = 4;

  // {size/sign code, write}
  typedef enum logic [3:0] {
    OP_LB  = 4'b0000,
    OP_SB  = 4'b0001,
    OP_LH  = 4'b0010,
    OP_SH  = 4'b0011,
    OP_LW  = 4'b0100,
    OP_SW  = 4'b0101,
    OP_LBU = 4'b1000,
    OP_LHU = 4'b1010
  } mem_op_e;

  // miss handling progress
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_RECV,
    FILL_DRAIN
  } fill_state_e;

endpackage

// ==== dcache/load_format.sv ====
// aligns the addressed byte, half or word of a 64-bit beat and extends it for the load op
`timescale 1ns/1ps

module load_format (
  input  dcache_pkg::mem_op_e                 s2_op,
  input  logic [2:0]                          s2_offset,
  input  logic [dcache_pkg::BEAT_W-1:0]       s2_data,
  output logic [31:0]                         rdata
);

  logic [31:0] word;
  logic [31:0] shifted;

  assign word = s2_offset[2] ? s2_data[63:32] : s2_data[31:0];
  assign shifted = word >> {s2_offset[1:0], 3'b000};

  always_comb begin
    case (s2_op)
      dcache_pkg::OP_LB:
        rdata = {{24{shifted[7]}}, shifted[7:0]};
      dcache_pkg::OP_LH:
        rdata = {{16{shifted[15]}}, shifted[15:0]};
      dcache_pkg::OP_LBU:
        rdata = {24'b0, shifted[7:0]};
      dcache_pkg::OP_LHU:
        rdata = {16'b0, shifted[15:0]};
      // word loads are aligned, pass through
      default:
        rdata = shifted;
    endcase
  end

endmodule

// ==== dcache/dcache_data_array.sv ====
// line data storage, one registered read port and one byte-masked write port
`timescale 1ns/1ps

module dcache_data_array #(
  parameter int SET_W = 7,
  localparam int IDX_W = SET_W + $clog2(dcache_pkg::WAYS) + $clog2(dcache_pkg::BEATS)
) (
  input  logic                              clk,
  input  logic                              rd_en,
  input  logic [IDX_W-1:0]                  rd_index,
  input  logic                              wr_en,
  input  logic [IDX_W-1:0]                  wr_index,
  input  logic [dcache_pkg::BEAT_W/8-1:0]   wr_mask,
  input  logic [dcache_pkg::BEAT_W-1:0]     wr_data,
  output logic [dcache_pkg::BEAT_W-1:0]     rd_data
);

  // indexed by {set, way, beat}
  logic [dcache_pkg::BEAT_W-1:0] mem [1 << IDX_W];

  always_ff @(posedge clk) begin
    if (rd_en)
      rd_data <= mem[rd_index];
    if (wr_en) begin
      for (int b = 0; b < dcache_pkg::BEAT_W / 8; b++) begin
        if (wr_mask[b])
          mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

endmodule

// ==== dcache/dcache_tag_array.sv ====
// per-set valid bits, tags and tree pseudo-LRU state with lookup and victim selection
`timescale 1ns/1ps

module dcache_tag_array #(
  parameter int SET_W = 7,
  localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - SET_W,
  localparam int WAY_W = $clog2(dcache_pkg::WAYS)
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [SET_W-1:0]              lookup_set,
  input  logic [TAG_W-1:0]              lookup_tag,
  input  logic                          lru_touch,
  input  logic [WAY_W-1:0]              lru_way,
  input  logic                          fill_start,
  input  logic                          tag_fill,
  input  logic [SET_W-1:0]              fill_set,
  input  logic [TAG_W-1:0]              fill_tag,
  input  logic [WAY_W-1:0]              fill_way,
  output logic [dcache_pkg::WAYS-1:0]   hit_way,
  output logic [WAY_W-1:0]              victim_way
);

  localparam int SETS = 1 << SET_W;

  logic [dcache_pkg::WAYS-1:0] valid_q [SETS];
  logic [2:0] lru_q [SETS];
  logic [TAG_W-1:0] tag_q [SETS][dcache_pkg::WAYS];

  logic [2:0] lru;

  always_comb begin
    for (int w = 0; w < dcache_pkg::WAYS; w++)
      hit_way[w] = valid_q[lookup_set][w] && tag_q[lookup_set][w] == lookup_tag;
  end

  // lowest invalid way, else follow the tree
  assign lru = lru_q[lookup_set];
  always_comb begin
    victim_way = lru[2] ? {1'b1, lru[1]} : {1'b0, lru[0]};
    for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_q[lookup_set][w])
        victim_way = WAY_W'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        lru_q[s] <= '0;
      end
    end else begin
      // victim way goes invalid while its line is refilled
      if (fill_start)
        valid_q[fill_set][fill_way] <= 1'b0;
      else if (tag_fill)
        valid_q[fill_set][fill_way] <= 1'b1;

      // point the tree away from the touched way
      if (lru_touch) begin
        if (lru_way[1]) begin
          lru_q[lookup_set][2] <= 1'b0;
          lru_q[lookup_set][1] <= ~lru_way[0];
        end else begin
          lru_q[lookup_set][2] <= 1'b1;
          lru_q[lookup_set][0] <= ~lru_way[0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_fill)
      tag_q[fill_set][fill_way] <= fill_tag;
  end

endmodule

// ==== dcache/dcache_miss_unit.sv ====
// single MSHR with an 8-beat read buffer, forwards the missed word and drains the line
`timescale 1ns/1ps

module dcache_miss_unit #(
  parameter int SET_W = 7,
  localparam int LINE_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W,
  localparam int TAG_W = LINE_W - SET_W,
  localparam int WAY_W = $clog2(dcache_pkg::WAYS),
  localparam int BEAT_SEL_W = $clog2(dcache_pkg::BEATS),
  localparam int IDX_W = SET_W + WAY_W + BEAT_SEL_W
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              alloc,
  input  logic [LINE_W-1:0]                 alloc_line_addr,
  input  logic [WAY_W-1:0]                  alloc_way,
  input  dcache_pkg::mem_op_e               alloc_op,
  input  logic [dcache_pkg::OFFSET_W-1:0]   alloc_offset,
  input  logic [dcache_pkg::ID_W-1:0]       alloc_id,
  input  logic                              l2_valid,
  input  logic [dcache_pkg::BEAT_W-1:0]     l2_rdata,
  input  logic                              fill_go,
  output logic                              line_busy,
  output logic [LINE_W-1:0]                 busy_line_addr,
  output logic                              fill_start,
  output logic                              tag_fill,
  output logic [SET_W-1:0]                  fill_set,
  output logic [TAG_W-1:0]                  fill_tag,
  output logic [WAY_W-1:0]                  fill_way,
  output logic                              fwd_valid,
  output dcache_pkg::mem_op_e               fwd_op,
  output logic [2:0]                        fwd_offset,
  output logic [dcache_pkg::ID_W-1:0]       fwd_id,
  output logic [dcache_pkg::BEAT_W-1:0]     fwd_data,
  output logic                              fill_wen,
  output logic [IDX_W-1:0]                  fill_index,
  output logic [dcache_pkg::BEAT_W-1:0]     fill_data
);

  dcache_pkg::fill_state_e state_q;

  // MSHR contents
  logic [LINE_W-1:0] line_q;
  logic [WAY_W-1:0] way_q;
  dcache_pkg::mem_op_e op_q;
  logic [dcache_pkg::OFFSET_W-1:0] offset_q;
  logic [dcache_pkg::ID_W-1:0] id_q;

  // arrived and drained beat counts
  logic [BEAT_SEL_W:0] tail_q, head_q;
  logic [dcache_pkg::BEAT_W-1:0] rbuf [dcache_pkg::BEATS];
  logic beat_in;

  assign line_busy = state_q != dcache_pkg::FILL_IDLE;
  assign busy_line_addr = line_q;
  assign fill_set = line_q[SET_W-1:0];
  assign fill_tag = line_q[LINE_W-1:SET_W];
  assign fill_way = way_q;

  assign beat_in = state_q == dcache_pkg::FILL_RECV && l2_valid;

  // missed load answered from its own beat
  assign fwd_valid = beat_in && tail_q[BEAT_SEL_W-1:0] == offset_q[dcache_pkg::OFFSET_W-1:3];
  assign fwd_op = op_q;
  assign fwd_offset = offset_q[2:0];
  assign fwd_id = id_q;
  assign fwd_data = l2_rdata;

  assign fill_wen = line_busy && head_q != tail_q;
  assign fill_index = {fill_set, way_q, head_q[BEAT_SEL_W-1:0]};
  assign fill_data = rbuf[head_q[BEAT_SEL_W-1:0]];
  assign tag_fill = fill_wen && fill_go && head_q == (BEAT_SEL_W+1)'(dcache_pkg::BEATS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dcache_pkg::FILL_IDLE;
      fill_start <= 1'b0;
      tail_q <= '0;
      head_q <= '0;
    end else begin
      fill_start <= alloc;
      case (state_q)
        dcache_pkg::FILL_IDLE: begin
          if (alloc) begin
            state_q <= dcache_pkg::FILL_RECV;
            tail_q <= '0;
            head_q <= '0;
          end
        end
        dcache_pkg::FILL_RECV: begin
          if (l2_valid && tail_q == (BEAT_SEL_W+1)'(dcache_pkg::BEATS - 1))
            state_q <= dcache_pkg::FILL_DRAIN;
        end
        default: begin
          if (tag_fill)
            state_q <= dcache_pkg::FILL_IDLE;
        end
      endcase
      if (beat_in)
        tail_q <= tail_q + 1'b1;
      if (fill_wen && fill_go)
        head_q <= head_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      line_q <= alloc_line_addr;
      way_q <= alloc_way;
      op_q <= alloc_op;
      offset_q <= alloc_offset;
      id_q <= alloc_id;
    end
    if (beat_in)
      rbuf[tail_q[BEAT_SEL_W-1:0]] <= l2_rdata;
  end

endmodule

// ==== dcache/dcache_pipeline.sv ====
// request pipeline: stage 0 lookup and hit/miss decision, stage 1 array read, stage 2 response
`timescale 1ns/1ps

module dcache_pipeline #(
  parameter int SET_W = 7,
  localparam int LINE_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W,
  localparam int TAG_W = LINE_W - SET_W,
  localparam int WAY_W = $clog2(dcache_pkg::WAYS),
  localparam int IDX_W = SET_W + WAY_W + $clog2(dcache_pkg::BEATS)
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                lsq_req,
  input  dcache_pkg::mem_op_e                 lsq_op,
  input  logic [dcache_pkg::ADDR_W-1:0]       lsq_addr,
  input  logic [dcache_pkg::ID_W-1:0]         lsq_id,
  input  logic [31:0]                         lsq_wdata,
  input  logic                                l2_ready,
  input  logic [dcache_pkg::WAYS-1:0]         hit_way,
  input  logic [WAY_W-1:0]                    victim_way,
  input  logic                                line_busy,
  input  logic [LINE_W-1:0]                   busy_line_addr,
  input  logic                                fwd_valid,
  input  dcache_pkg::mem_op_e                 fwd_op,
  input  logic [2:0]                          fwd_offset,
  input  logic [dcache_pkg::ID_W-1:0]         fwd_id,
  input  logic [dcache_pkg::BEAT_W-1:0]       fwd_data,
  input  logic                                fill_wen,
  input  logic [IDX_W-1:0]                    fill_index,
  input  logic [dcache_pkg::BEAT_W-1:0]       fill_data,
  input  logic [dcache_pkg::BEAT_W-1:0]       rd_data,
  output logic                                lsq_ready,
  output logic                                l2_req,
  output logic [dcache_pkg::ADDR_W-1:2]       l2_addr,
  output logic                                l2_wen,
  output logic [3:0]                          l2_wmask,
  output logic [31:0]                         l2_wdata,
  output logic [SET_W-1:0]                    lookup_set,
  output logic [TAG_W-1:0]                    lookup_tag,
  output logic                                lru_touch,
  output logic [WAY_W-1:0]                    lru_way,
  output logic                                alloc,
  output logic [LINE_W-1:0]                   alloc_line_addr,
  output logic [WAY_W-1:0]                    alloc_way,
  output dcache_pkg::mem_op_e                 alloc_op,
  output logic [dcache_pkg::OFFSET_W-1:0]     alloc_offset,
  output logic [dcache_pkg::ID_W-1:0]         alloc_id,
  output logic                                fill_go,
  output logic                                rd_en,
  output logic [IDX_W-1:0]                    rd_index,
  output logic                                wr_en,
  output logic [IDX_W-1:0]                    wr_index,
  output logic [dcache_pkg::BEAT_W/8-1:0]     wr_mask,
  output logic [dcache_pkg::BEAT_W-1:0]       wr_data,
  output logic                                s2_valid,
  output dcache_pkg::mem_op_e                 s2_op,
  output logic [2:0]                          s2_offset,
  output logic [dcache_pkg::ID_W-1:0]         s2_id,
  output logic [dcache_pkg::BEAT_W-1:0]       s2_data
);

  logic s0_valid;
  dcache_pkg::mem_op_e s0_op;
  logic [dcache_pkg::ADDR_W-1:0] s0_addr;
  logic [dcache_pkg::ID_W-1:0] s0_id;
  logic [31:0] s0_wdata;

  logic s0_write, s0_hit, line_match, load_hit, load_miss, store, store_wr;
  logic s0_stall, s1_stall;
  logic [WAY_W-1:0] hit_idx;
  logic [3:0] wmask;

  // stage 1 issue and read-return registers
  logic s1_valid, s1r_valid;
  logic [IDX_W-1:0] s1_index;
  dcache_pkg::mem_op_e s1_op, s1r_op;
  logic [2:0] s1_offset, s1r_offset;
  logic [dcache_pkg::ID_W-1:0] s1_id, s1r_id;

  assign s0_write = s0_op[0];
  assign lookup_set = s0_addr[dcache_pkg::OFFSET_W +: SET_W];
  assign lookup_tag = s0_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
  assign s0_hit = |hit_way;

  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      if (hit_way[w])
        hit_idx = WAY_W'(w);
    end
  end

  // anything touching the line under fill waits for it
  assign line_match = line_busy && busy_line_addr == s0_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
  assign load_hit = s0_valid & ~s0_write & ~line_match & s0_hit;
  assign load_miss = s0_valid & ~s0_write & ~line_match & ~s0_hit;
  assign store = s0_valid & s0_write & ~line_match;
  assign store_wr = store & s0_hit & l2_ready;

  assign s1_stall = fwd_valid & s1r_valid;
  assign s0_stall = s0_valid & (line_match | (s0_write & ~l2_ready) |
                    (load_miss & (line_busy | ~l2_ready)) | (load_hit & s1_stall));
  assign lsq_ready = ~s0_stall;

  always_ff @(posedge clk) begin
    if (rst)
      s0_valid <= 1'b0;
    else if (!s0_stall)
      s0_valid <= lsq_req;
  end

  always_ff @(posedge clk) begin
    if (!s0_stall && lsq_req) begin
      s0_op <= lsq_op;
      s0_addr <= lsq_addr;
      s0_id <= lsq_id;
      s0_wdata <= lsq_wdata;
    end
  end

  // L2 request, reads are line aligned
  assign l2_req = store | (load_miss & ~line_busy);
  assign l2_wen = s0_write;
  assign l2_addr = s0_write ? s0_addr[dcache_pkg::ADDR_W-1:2] :
                   {s0_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], 4'b0000};

  always_comb begin
    case (s0_op[2:1])
      2'b00: begin
        wmask = 4'b0001 << s0_addr[1:0];
        l2_wdata = {4{s0_wdata[7:0]}};
      end
      2'b01: begin
        wmask = s0_addr[1] ? 4'b1100 : 4'b0011;
        l2_wdata = {2{s0_wdata[15:0]}};
      end
      default: begin
        wmask = 4'b1111;
        l2_wdata = s0_wdata;
      end
    endcase
  end
  assign l2_wmask = wmask;

  assign alloc = load_miss & ~line_busy & l2_ready;
  assign alloc_line_addr = s0_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
  assign alloc_way = victim_way;
  assign alloc_op = s0_op;
  assign alloc_offset = s0_addr[dcache_pkg::OFFSET_W-1:0];
  assign alloc_id = s0_id;

  assign lru_touch = (s0_valid & ~line_match & s0_hit & ~s0_stall) | alloc;
  assign lru_way = s0_hit ? hit_idx : victim_way;

  // store hit owns the write port, fill waits
  assign fill_go = ~store_wr;
  assign wr_en = store_wr | fill_wen;
  assign wr_index = store_wr ? {lookup_set, hit_idx, s0_addr[5:3]} : fill_index;
  assign wr_mask = store_wr ? (s0_addr[2] ? {wmask, 4'b0000} : {4'b0000, wmask}) : '1;
  assign wr_data = store_wr ? {2{l2_wdata}} : fill_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1r_valid <= 1'b0;
    end else if (!s1_stall) begin
      s1_valid <= load_hit;
      s1r_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!s1_stall) begin
      s1_index <= {lookup_set, hit_idx, s0_addr[5:3]};
      s1_op <= s0_op;
      s1_offset <= s0_addr[2:0];
      s1_id <= s0_id;
      s1r_op <= s1_op;
      s1r_offset <= s1_offset;
      s1r_id <= s1_id;
    end
  end

  // read held while stage 1 is stalled
  assign rd_en = s1_valid & ~s1_stall;
  assign rd_index = s1_index;

  always_ff @(posedge clk) begin
    if (rst)
      s2_valid <= 1'b0;
    else
      s2_valid <= fwd_valid | s1r_valid;
  end

  // forwarded beat has priority
  always_ff @(posedge clk) begin
    if (fwd_valid) begin
      s2_op <= fwd_op;
      s2_offset <= fwd_offset;
      s2_id <= fwd_id;
      s2_data <= fwd_data;
    end else begin
      s2_op <= s1r_op;
      s2_offset <= s1r_offset;
      s2_id <= s1r_id;
      s2_data <= rd_data;
    end
  end

endmodule

// ==== dcache/dcache.sv ====
// write-through 4-way data cache top level, connects the lsq and L2 ports to the sub-blocks
`timescale 1ns/1ps

module dcache #(
  parameter int SET_W = 7,
  localparam int LINE_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W,
  localparam int TAG_W = LINE_W - SET_W,
  localparam int WAY_W = $clog2(dcache_pkg::WAYS),
  localparam int IDX_W = SET_W + WAY_W + $clog2(dcache_pkg::BEATS)
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              lsq_req,
  input  dcache_pkg::mem_op_e               lsq_op,
  input  logic [dcache_pkg::ADDR_W-1:0]     lsq_addr,
  input  logic [dcache_pkg::ID_W-1:0]       lsq_id,
  input  logic [31:0]                       lsq_wdata,
  output logic                              lsq_ready,
  output logic                              lsq_valid,
  output logic [dcache_pkg::ID_W-1:0]       lsq_resp_id,
  output logic [31:0]                       lsq_rdata,
  output logic                              l2_req,
  output logic [dcache_pkg::ADDR_W-1:2]     l2_addr,
  output logic                              l2_wen,
  output logic [3:0]                        l2_wmask,
  output logic [31:0]                       l2_wdata,
  input  logic                              l2_ready,
  input  logic                              l2_valid,
  input  logic [dcache_pkg::BEAT_W-1:0]     l2_rdata
);

  logic [SET_W-1:0] lookup_set;
  logic [TAG_W-1:0] lookup_tag;
  logic [dcache_pkg::WAYS-1:0] hit_way;
  logic [WAY_W-1:0] victim_way, lru_way, alloc_way, fill_way;
  logic lru_touch;

  // miss allocation and fill
  logic alloc, line_busy, fill_start, tag_fill, fill_go, fill_wen;
  logic [LINE_W-1:0] alloc_line_addr, busy_line_addr;
  dcache_pkg::mem_op_e alloc_op, fwd_op, s2_op;
  logic [dcache_pkg::OFFSET_W-1:0] alloc_offset;
  logic [dcache_pkg::ID_W-1:0] alloc_id, fwd_id, s2_id;
  logic [SET_W-1:0] fill_set;
  logic [TAG_W-1:0] fill_tag;
  logic fwd_valid, s2_valid;
  logic [2:0] fwd_offset, s2_offset;
  logic [dcache_pkg::BEAT_W-1:0] fwd_data, fill_data, rd_data, wr_data, s2_data;
  logic [IDX_W-1:0] fill_index, rd_index, wr_index;

  // data array ports
  logic rd_en, wr_en;
  logic [dcache_pkg::BEAT_W/8-1:0] wr_mask;

  dcache_pipeline #(.SET_W(SET_W)) u_pipeline (.*);

  dcache_tag_array #(.SET_W(SET_W)) u_tag_array (.*);

  dcache_data_array #(.SET_W(SET_W)) u_data_array (.*);

  dcache_miss_unit #(.SET_W(SET_W)) u_miss_unit (.*);

  load_format u_load_format (
    .s2_op    (s2_op),
    .s2_offset(s2_offset),
    .s2_data  (s2_data),
    .rdata    (lsq_rdata)
  );

  assign lsq_valid = s2_valid;
  assign lsq_resp_id = s2_id;

endmodule

// ==== testbench/l2_model.sv ====
// L2 memory model for the cache testbench, masked word writes and delayed 8-beat line reads
`timescale 1ns/1ps

module l2_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        ready_en,
  input  logic [3:0]  delay,
  input  logic        l2_req,
  input  logic [31:2] l2_addr,
  input  logic        l2_wen,
  input  logic [3:0]  l2_wmask,
  input  logic [31:0] l2_wdata,
  output logic        l2_ready,
  output logic        l2_valid,
  output logic [63:0] l2_rdata,
  output int          read_count
);

  // words never written hold the address pattern
  logic [31:0] mem [int unsigned];
  logic [31:0] line [16];
  logic [31:0] w;
  logic busy;
  logic [3:0] wait_cnt;
  logic [2:0] beat;

  function automatic logic [31:0] word_at(input logic [29:0] waddr);
    if (mem.exists({2'b00, waddr}))
      return mem[{2'b00, waddr}];
    return {2'b00, waddr} * 32'h9E3779B1;
  endfunction

  assign l2_ready = ready_en;

  always @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      l2_valid <= 1'b0;
      read_count <= 0;
    end else begin
      l2_valid <= 1'b0;
      if (l2_req && l2_ready) begin
        if (l2_wen) begin
          w = word_at(l2_addr);
          for (int b = 0; b < 4; b++) begin
            if (l2_wmask[b])
              w[b*8 +: 8] = l2_wdata[b*8 +: 8];
          end
          mem[{2'b00, l2_addr}] = w;
        end else begin
          // snapshot of the whole line at request time
          for (int i = 0; i < 16; i++)
            line[i] <= word_at(l2_addr + 30'(i));
          busy <= 1'b1;
          wait_cnt <= delay;
          beat <= 3'd0;
          read_count <= read_count + 1;
        end
      end
      if (busy) begin
        if (wait_cnt != 4'd0) begin
          wait_cnt <= wait_cnt - 4'd1;
        end else begin
          l2_valid <= 1'b1;
          l2_rdata <= {line[{beat, 1'b1}], line[{beat, 1'b0}]};
          beat <= beat + 3'd1;
          if (beat == 3'd7)
            busy <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== testbench/dcache_tb.sv ====
// directed testbench for the data cache, checks load data and L2 read counts against a reference
`timescale 1ns/1ps

module dcache_tb;

  logic clk;
  logic rst;
  logic lsq_req;
  dcache_pkg::mem_op_e lsq_op;
  logic [31:0] lsq_addr;
  logic [dcache_pkg::ID_W-1:0] lsq_id;
  logic [31:0] lsq_wdata;
  logic lsq_ready, lsq_valid;
  logic [dcache_pkg::ID_W-1:0] lsq_resp_id;
  logic [31:0] lsq_rdata;
  logic l2_req, l2_wen, l2_ready, l2_valid;
  logic [31:2] l2_addr;
  logic [3:0] l2_wmask;
  logic [31:0] l2_wdata;
  logic [63:0] l2_rdata;
  logic ready_en;
  logic [3:0] delay;
  int read_count;

  logic [31:0] ref_mem [int unsigned];
  logic [31:0] expected [16];
  logic [31:0] resp_data [16];
  int resp_cnt [16];
  logic [dcache_pkg::ID_W-1:0] next_id;
  int ops_issued;
  logic throttle;
  logic [31:0] seed;

  dcache #(.SET_W(7)) dut (.*);

  l2_model l2m (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ready and read delay from the generator
  always @(negedge clk) begin
    seed = lcg(seed);
    ready_en = throttle ? seed[16] : 1'b1;
    delay = {1'b0, seed[19:17]} + 4'd1;
  end

  always @(negedge clk) begin
    if (lsq_valid) begin
      resp_cnt[lsq_resp_id] = resp_cnt[lsq_resp_id] + 1;
      resp_data[lsq_resp_id] = lsq_rdata;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 400 * (ops_issued + 1) + 10) begin
        $display("STATUS: FAIL");
        $fatal(1, "timeout: the cache stopped responding");
      end
    end
  end

  function automatic logic [31:0] ref_word(input logic [29:0] waddr);
    if (ref_mem.exists({2'b00, waddr}))
      return ref_mem[{2'b00, waddr}];
    return {2'b00, waddr} * 32'h9E3779B1;
  endfunction

  function automatic logic [31:0] expect_load(input dcache_pkg::mem_op_e op,
                                              input logic [31:0] addr);
    logic [31:0] w;
    w = ref_word(addr[31:2]) >> (8 * addr[1:0]);
    case (op)
      dcache_pkg::OP_LB: return {{24{w[7]}}, w[7:0]};
      dcache_pkg::OP_LBU: return {24'h0, w[7:0]};
      dcache_pkg::OP_LH: return {{16{w[15]}}, w[15:0]};
      dcache_pkg::OP_LHU: return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic check_rdata(input logic [dcache_pkg::ID_W-1:0] id, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail lsq_rdata id %h: got %h expected %h", id, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "load data mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  // hold the request until the cache takes it
  task automatic send(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                      input logic [dcache_pkg::ID_W-1:0] id, input logic [31:0] wdata);
    logic taken;
    taken = 1'b0;
    @(negedge clk);
    lsq_req = 1'b1;
    lsq_op = op;
    lsq_addr = addr;
    lsq_id = id;
    lsq_wdata = wdata;
    ops_issued++;
    while (!taken) begin
      #10;
      taken = lsq_ready;
      @(negedge clk);
    end
    lsq_req = 1'b0;
  endtask

  task automatic store(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                       input logic [31:0] data);
    logic [31:0] w;
    w = ref_word(addr[31:2]);
    case (op)
      dcache_pkg::OP_SB: w[8*addr[1:0] +: 8] = data[7:0];
      dcache_pkg::OP_SH: w[16*addr[1] +: 16] = data[15:0];
      default: w = data;
    endcase
    ref_mem[{2'b00, addr[31:2]}] = w;
    send(op, addr, next_id, data);
    next_id++;
  endtask

  task automatic load_issue(input dcache_pkg::mem_op_e op, input logic [31:0] addr,
                            output logic [dcache_pkg::ID_W-1:0] id);
    id = next_id;
    next_id++;
    expected[id] = expect_load(op, addr);
    resp_cnt[id] = 0;
    send(op, addr, id, 32'h0);
  endtask

  task automatic load_wait(input logic [dcache_pkg::ID_W-1:0] id);
    while (resp_cnt[id] == 0)
      @(negedge clk);
    check_rdata(id, resp_data[id], expected[id]);
  endtask

  task automatic load(input dcache_pkg::mem_op_e op, input logic [31:0] addr);
    logic [dcache_pkg::ID_W-1:0] id;
    load_issue(op, addr, id);
    load_wait(id);
  endtask

  task automatic test_cold_line();
    int base;
    base = read_count;
    load(dcache_pkg::OP_LW, 32'h1008);
    check_count("l2 reads", read_count, base + 1);
    load(dcache_pkg::OP_LW, 32'h1030);
    check_count("l2 reads", read_count, base + 1);
  endtask

  task automatic test_extend();
    for (int a = 32'h1010; a < 32'h1018; a++) begin
      load(dcache_pkg::OP_LB, a);
      load(dcache_pkg::OP_LBU, a);
      if (a % 2 == 0) begin
        load(dcache_pkg::OP_LH, a);
        load(dcache_pkg::OP_LHU, a);
      end
    end
  endtask

  task automatic test_stores();
    int base;
    base = read_count;
    store(dcache_pkg::OP_SB, 32'h1021, 32'h000000A5);
    store(dcache_pkg::OP_SH, 32'h1026, 32'h00008001);
    store(dcache_pkg::OP_SW, 32'h1028, 32'h12345678);
    load(dcache_pkg::OP_LW, 32'h1020);
    load(dcache_pkg::OP_LW, 32'h1024);
    load(dcache_pkg::OP_LW, 32'h1028);
    check_count("l2 reads", read_count, base);
    // no write-allocate on a miss
    store(dcache_pkg::OP_SW, 32'h3044, 32'hCAFEF00D);
    store(dcache_pkg::OP_SB, 32'h3042, 32'h0000007E);
    check_count("l2 reads", read_count, base);
    load(dcache_pkg::OP_LW, 32'h3040);
    check_count("l2 reads", read_count, base + 1);
    load(dcache_pkg::OP_LW, 32'h3044);
    check_count("l2 reads", read_count, base + 1);
  endtask

  // five lines of set 5, 0x2000 apart
  task automatic test_replace();
    int base;
    for (int k = 0; k < 4; k++)
      load(dcache_pkg::OP_LW, 32'h10140 + k * 32'h2000);
    base = read_count;
    // after touching ways 2 then 0 the tree points at way 3
    load(dcache_pkg::OP_LW, 32'h14144);
    load(dcache_pkg::OP_LW, 32'h10148);
    load(dcache_pkg::OP_LW, 32'h18140);
    check_count("l2 reads", read_count, base + 1);
    for (int k = 0; k < 3; k++)
      load(dcache_pkg::OP_LW, 32'h1014C + k * 32'h2000);
    load(dcache_pkg::OP_LW, 32'h18150);
    check_count("l2 reads", read_count, base + 1);
    load(dcache_pkg::OP_LW, 32'h16140);
    check_count("l2 reads", read_count, base + 2);
  endtask

  task automatic test_hit_under_miss();
    logic [dcache_pkg::ID_W-1:0] ids [5];
    throttle = 1'b1;
    load_issue(dcache_pkg::OP_LH, 32'h2008A, ids[0]);
    load_issue(dcache_pkg::OP_LW, 32'h1004, ids[1]);
    load_issue(dcache_pkg::OP_LW, 32'h12148, ids[2]);
    load_issue(dcache_pkg::OP_LBU, 32'h1039, ids[3]);
    load_issue(dcache_pkg::OP_LW, 32'h18150, ids[4]);
    for (int i = 0; i < 5; i++)
      load_wait(ids[i]);
    repeat (30) @(negedge clk);
    for (int i = 0; i < 5; i++)
      check_count("responses per id", resp_cnt[ids[i]], 1);
    throttle = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    lsq_req = 1'b0;
    lsq_op = dcache_pkg::OP_LW;
    lsq_addr = 32'h0;
    lsq_id = '0;
    lsq_wdata = 32'h0;
    ready_en = 1'b1;
    delay = 4'd2;
    throttle = 1'b0;
    seed = 32'd3384;
    next_id = '0;
    ops_issued = 0;
    for (int i = 0; i < 16; i++)
      resp_cnt[i] = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_cold_line();
    test_extend();
    test_stores();
    test_replace();
    test_hit_under_miss();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
common/dcache_pkg.sv
dcache/load_format.sv
dcache/dcache_data_array.sv
dcache/dcache_tag_array.sv
dcache/dcache_miss_unit.sv
dcache/dcache_pipeline.sv
dcache/dcache.sv
testbench/l2_model.sv
testbench/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = dcache_tb
FILELIST = sources.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
